/* verif/udp_tx_testdata.txt */
// Columns: type arg0 arg1 arg2, all hex. 1 config mac ip port, 2 gateway index,
// 3 arp index mac, 4 enable value wait, 5 frame ip port words, 6 burst words, 0 end
1 02005e100001 0a000102 c350
2 01 0 0
3 07 a0b1c2d3e407 0
3 08 a0b1c2d3e408 0
3 05 a0b1c2d3e405 0
3 01 f0e1d2c3b401 0
4 1 0 0
5 0a000107 1f90 1
5 0a000108 1f91 7
5 c0a80a05 0035 3
5 0a000107 2000 2
5 0a000108 2001 4
5 c0a80a05 2002 1
4 0 0 0
5 0a000107 3000 3
5 0a000108 3001 2
4 1 40 0
6 210 0 0
5 0a000107 4000 2
0 0 0 0

/* udp_tx.f */
hw/udp_tx_pkg.sv
hw/udp_tx_sync_fifo.sv
hw/udp_tx_frame_buffer.sv
hw/udp_tx_header_calc.sv
hw/udp_tx_framer.sv
hw/udp_tx_top.sv
verif/udp_tx_tb.sv

/* Makefile */
SIM := obj_dir/Vudp_tx_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module udp_tx_tb -f udp_tx.f

run: compile
	$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then exit 1; fi
	@grep -q '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/udp_tx_tb.sv */
`timescale 1ns/1ps

module udp_tx_tb
  import udp_tx_pkg::*;
();

  logic       mac_clk;
  logic       app_rst;
  logic       local_enable;
  mac_addr_t  local_mac;
  ip_addr_t   local_ip;
  udp_port_t  local_port;
  arp_index_t local_gateway;
  logic       arp_wr_en;
  arp_index_t arp_wr_index;
  mac_addr_t  arp_wr_mac;
  logic       app_tx_valid;
  logic       app_tx_end_of_frame;
  word_t      app_tx_data;
  ip_addr_t   app_tx_dest_ip;
  udp_port_t  app_tx_dest_port;
  logic       app_tx_afull;
  logic       app_tx_overflow;
  word_t      mac_tx_data;
  byte_en_t   mac_tx_data_valid;
  logic       mac_tx_start;
  logic       mac_tx_ack;

  // Records of four words each: type, then three arguments
  word_t      testdata [256];
  mac_addr_t  arp_model [256];
  ip_addr_t   exp_ip [$];
  udp_port_t  exp_port [$];
  int         exp_words [$];
  mac_addr_t  exp_mac [$];
  word_t      exp_data [$];
  logic [7:0] frame_bytes [1024];

  int   value_errors    = 0;
  int   other_errors    = 0;
  int   start_count     = 0;
  int   frames_queued   = 0;
  int   frame_no        = 0;
  int   watchdog_cycles = 0;
  int   afull_cycle;
  int   ovf_cycle;
  logic busy            = 1'b0;
  logic blocked         = 1'b0;

  udp_tx_top i_dut (
    .mac_clk             (mac_clk),
    .app_rst             (app_rst),
    .local_enable        (local_enable),
    .local_mac           (local_mac),
    .local_ip            (local_ip),
    .local_port          (local_port),
    .local_gateway       (local_gateway),
    .arp_wr_en           (arp_wr_en),
    .arp_wr_index        (arp_wr_index),
    .arp_wr_mac          (arp_wr_mac),
    .app_tx_valid        (app_tx_valid),
    .app_tx_end_of_frame (app_tx_end_of_frame),
    .app_tx_data         (app_tx_data),
    .app_tx_dest_ip      (app_tx_dest_ip),
    .app_tx_dest_port    (app_tx_dest_port),
    .app_tx_afull        (app_tx_afull),
    .app_tx_overflow     (app_tx_overflow),
    .mac_tx_data         (mac_tx_data),
    .mac_tx_data_valid   (mac_tx_data_valid),
    .mac_tx_start        (mac_tx_start),
    .mac_tx_ack          (mac_tx_ack)
  );

  initial begin
    mac_clk = 1'b0;
  end

  always #2 mac_clk = ~mac_clk;

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_byte_en(input string name, input byte_en_t got, input byte_en_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    other_errors++;
  endtask

  // Varied bytes so a lane swap shows up
  function automatic word_t payload_word(int frame, int idx);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = (frame * 32'h0100_0193) ^ idx ^ 32'hc3a5_0000;
    lo = ~(idx * 32'h9e37_79b9) ^ frame;
    return {hi, lo};
  endfunction

  function automatic logic [15:0] header_checksum(ip_addr_t src, ip_addr_t dst,
                                                  logic [15:0] len);
    logic [31:0] sum;
    sum = 32'h0000_8412 + {16'h0, len} + {16'h0, src[31:16]} + {16'h0, src[15:0]}
        + {16'h0, dst[31:16]} + {16'h0, dst[15:0]};
    sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    return ~sum[15:0];
  endfunction

  // Gateway entry for anything off the local /24
  function automatic mac_addr_t expected_mac(ip_addr_t ip);
    if (ip[31:8] == local_ip[31:8]) begin
      return arp_model[ip[7:0]];
    end
    return arp_model[local_gateway];
  endfunction

  // Wire byte stream of one frame, header then payload MSB first
  task automatic build_frame(mac_addr_t mac, ip_addr_t ip, udp_port_t port, int n);
    logic [335:0] hdr;
    logic [15:0]  ip_len;
    logic [15:0]  udp_len;
    word_t        w;
    ip_len  = 16'(8 * n + 28);
    udp_len = 16'(8 * n + 8);
    hdr = {mac, local_mac, 16'h0800, 8'h45, 8'h00, ip_len, 16'h0000, 8'h40, 8'h00,
           8'hff, 8'h11, header_checksum(local_ip, ip, ip_len), local_ip, ip,
           local_port, port, udp_len, 16'h0000};
    for (int i = 0; i < 1024; i++) begin
      frame_bytes[i] = 8'h00;
    end
    for (int i = 0; i < 42; i++) begin
      frame_bytes[i] = hdr[335 - 8 * i -: 8];
    end
    for (int k = 0; k < n; k++) begin
      w = exp_data.pop_front();
      for (int i = 0; i < 8; i++) begin
        frame_bytes[42 + 8 * k + i] = w[63 - 8 * i -: 8];
      end
    end
  endtask

  task automatic check_beat(int b, int n);
    word_t    exp_w;
    word_t    mask;
    byte_en_t exp_en;
    for (int j = 0; j < 8; j++) begin
      exp_w[8 * j +: 8] = frame_bytes[8 * b + j];
    end
    exp_en = (b == n + 5) ? 8'h03 : 8'hff;
    mask   = (b == n + 5) ? 64'h0000_0000_0000_ffff : '1;
    check_flag("mac_tx_start", mac_tx_start, 1'b0);
    check_byte_en("mac_tx_data_valid", mac_tx_data_valid, exp_en);
    check_word("mac_tx_data", mac_tx_data & mask, exp_w & mask);
  endtask

  task automatic receive_frame();
    int n;
    n = exp_words.pop_front();
    build_frame(exp_mac.pop_front(), exp_ip.pop_front(), exp_port.pop_front(), n);
    busy = 1'b1;
    // First beat repeats until the MAC acks
    do begin
      @(negedge mac_clk);
      check_beat(0, n);
    end while (!mac_tx_ack);
    for (int b = 1; b <= n + 5; b++) begin
      @(negedge mac_clk);
      check_beat(b, n);
    end
    busy = 1'b0;
  endtask

  always begin
    @(negedge mac_clk);
    if (!app_rst) begin
      check_byte_en("mac_tx_data_valid", mac_tx_data_valid, 8'h00);
      if (mac_tx_start) begin
        start_count++;
        if (!local_enable) begin
          report_error("mac_tx_start appeared while local_enable was low");
        end
        if (exp_words.size() == 0) begin
          report_error("mac_tx_start appeared with no frame expected");
        end else begin
          receive_frame();
        end
      end
    end
  end

  // MAC side ack, 0 to 3 cycles into the first header beat
  initial begin
    int unsigned delay;
    mac_tx_ack = 1'b0;
    void'($urandom(32'h6931_59c7));
    forever begin
      @(negedge mac_clk);
      if (mac_tx_start) begin
        delay = $urandom % 4;
        @(posedge mac_clk);
        repeat (delay) @(posedge mac_clk);
        #0.5;
        mac_tx_ack = 1'b1;
        @(posedge mac_clk);
        #0.5;
        mac_tx_ack = 1'b0;
      end
    end
  end

  task automatic drive_idle();
    if (app_tx_valid) begin
      @(posedge mac_clk);
      #0.5;
      app_tx_valid        = 1'b0;
      app_tx_end_of_frame = 1'b0;
    end
  endtask

  task automatic apply_config(mac_addr_t mac, ip_addr_t ip, udp_port_t port);
    drive_idle();
    @(posedge mac_clk);
    #0.5;
    local_mac  = mac;
    local_ip   = ip;
    local_port = port;
  endtask

  task automatic set_gateway(arp_index_t idx);
    drive_idle();
    @(posedge mac_clk);
    #0.5;
    local_gateway = idx;
  endtask

  task automatic write_arp(arp_index_t idx, mac_addr_t mac);
    drive_idle();
    arp_model[idx] = mac;
    @(posedge mac_clk);
    #0.5;
    arp_wr_en    = 1'b1;
    arp_wr_index = idx;
    arp_wr_mac   = mac;
    @(posedge mac_clk);
    #0.5;
    arp_wr_en = 1'b0;
  endtask

  task automatic set_enable(logic value, int delay);
    drive_idle();
    repeat (delay) @(posedge mac_clk);
    @(posedge mac_clk);
    #0.5;
    local_enable = value;
  endtask

  task automatic write_frame(ip_addr_t ip, udp_port_t port, int n);
    word_t w;
    if (!blocked) begin
      exp_ip.push_back(ip);
      exp_port.push_back(port);
      exp_words.push_back(n);
      exp_mac.push_back(expected_mac(ip));
      frames_queued++;
    end
    for (int i = 0; i < n; i++) begin
      w = payload_word(frame_no, i);
      if (!blocked) begin
        exp_data.push_back(w);
      end
      @(posedge mac_clk);
      #0.5;
      app_tx_valid        = 1'b1;
      app_tx_data         = w;
      app_tx_end_of_frame = (i == n - 1);
      app_tx_dest_ip      = ip;
      app_tx_dest_port    = port;
    end
    frame_no++;
  endtask

  task automatic wait_drained();
    while (exp_words.size() != 0 || busy) begin
      @(negedge mac_clk);
    end
  endtask

  task automatic note_burst_flags(int cyc);
    if (app_tx_afull && afull_cycle < 0) begin
      afull_cycle = cyc;
    end
    if (app_tx_overflow && ovf_cycle < 0) begin
      ovf_cycle = cyc;
    end
  endtask

  // Payload with no end of frame until the data FIFO overflows
  task automatic overflow_burst(int n);
    drive_idle();
    wait_drained();
    check_flag("app_tx_afull", app_tx_afull, 1'b0);
    check_flag("app_tx_overflow", app_tx_overflow, 1'b0);
    afull_cycle = -1;
    ovf_cycle   = -1;
    for (int i = 0; i < n + 4; i++) begin
      @(posedge mac_clk);
      #0.5;
      app_tx_valid        = (i < n);
      app_tx_end_of_frame = 1'b0;
      app_tx_data         = payload_word(frame_no, i);
      @(negedge mac_clk);
      note_burst_flags(i);
    end
    if (afull_cycle < 0) begin
      report_error("app_tx_afull never rose during the burst");
    end
    if (ovf_cycle < 0) begin
      report_error("app_tx_overflow never rose during the burst");
    end else if (ovf_cycle <= afull_cycle) begin
      report_error("app_tx_overflow rose before app_tx_afull");
    end
    blocked = 1'b1;
  endtask

  initial begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge mac_clk);
    $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int    r;
    int    total;
    word_t op;
    $readmemh("verif/udp_tx_testdata.txt", testdata);
    for (int i = 0; i < 256; i++) begin
      arp_model[i] = '0;
    end
    total = 0;
    for (r = 0; r < 64 && testdata[4 * r] != 0; r++) begin
      if (testdata[4 * r] == 5) begin
        total += int'(testdata[4 * r + 3]);
      end else if (testdata[4 * r] == 6) begin
        total += int'(testdata[4 * r + 1]);
      end
    end
    watchdog_cycles = total * 20 + 2000;

    app_rst             = 1'b1;
    local_enable        = 1'b0;
    local_mac           = '0;
    local_ip            = '0;
    local_port          = '0;
    local_gateway       = '0;
    arp_wr_en           = 1'b0;
    arp_wr_index        = '0;
    arp_wr_mac          = '0;
    app_tx_valid        = 1'b0;
    app_tx_end_of_frame = 1'b0;
    app_tx_data         = '0;
    app_tx_dest_ip      = '0;
    app_tx_dest_port    = '0;
    repeat (16) @(posedge mac_clk);
    #0.5;
    app_rst = 1'b0;
    @(negedge mac_clk);
    check_flag("mac_tx_start", mac_tx_start, 1'b0);
    check_byte_en("mac_tx_data_valid", mac_tx_data_valid, 8'h00);
    check_flag("app_tx_afull", app_tx_afull, 1'b0);
    check_flag("app_tx_overflow", app_tx_overflow, 1'b0);

    r  = 0;
    op = testdata[0];
    while (op != 0 && r < 64) begin
      case (op)
        1: apply_config(testdata[4 * r + 1][47:0], testdata[4 * r + 2][31:0],
                        testdata[4 * r + 3][15:0]);
        2: set_gateway(testdata[4 * r + 1][7:0]);
        3: write_arp(testdata[4 * r + 1][7:0], testdata[4 * r + 2][47:0]);
        4: set_enable(testdata[4 * r + 1][0], int'(testdata[4 * r + 2]));
        5: write_frame(testdata[4 * r + 1][31:0], testdata[4 * r + 2][15:0],
                       int'(testdata[4 * r + 3]));
        6: overflow_burst(int'(testdata[4 * r + 1]));
        default: report_error("unknown record type in the test data");
      endcase
      r++;
      op = testdata[4 * r];
    end

    drive_idle();
    wait_drained();
    repeat (100) @(negedge mac_clk);
    if (blocked) begin
      check_flag("app_tx_overflow", app_tx_overflow, 1'b1);
    end
    if (start_count != frames_queued) begin
      report_error("number of mac_tx_start pulses differs from the frames sent");
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* hw/udp_tx_top.sv */
`timescale 1ns/1ps

module udp_tx_top
  import udp_tx_pkg::*;
(
  input  logic       mac_clk,
  input  logic       app_rst,
  input  logic       local_enable,
  input  mac_addr_t  local_mac,
  input  ip_addr_t   local_ip,
  input  udp_port_t  local_port,
  input  arp_index_t local_gateway,
  input  logic       arp_wr_en,
  input  arp_index_t arp_wr_index,
  input  mac_addr_t  arp_wr_mac,
  input  logic       app_tx_valid,
  input  logic       app_tx_end_of_frame,
  input  word_t      app_tx_data,
  input  ip_addr_t   app_tx_dest_ip,
  input  udp_port_t  app_tx_dest_port,
  output logic       app_tx_afull,
  output logic       app_tx_overflow,
  output word_t      mac_tx_data,
  output byte_en_t   mac_tx_data_valid,
  output logic       mac_tx_start,
  input  logic       mac_tx_ack
);

  word_t       data_word;
  ip_addr_t    ctrl_ip;
  udp_port_t   ctrl_port;
  word_count_t ctrl_words;
  logic        ctrl_empty;
  logic        data_pop;
  logic        ctrl_pop;
  mac_addr_t   dest_mac;
  logic [15:0] ip_length;
  logic [15:0] udp_length;
  logic [15:0] ip_checksum;
  logic        hdr_ready;

  udp_tx_frame_buffer i_frame_buffer (
    .mac_clk             (mac_clk),
    .app_rst             (app_rst),
    .app_tx_valid        (app_tx_valid),
    .app_tx_end_of_frame (app_tx_end_of_frame),
    .app_tx_data         (app_tx_data),
    .app_tx_dest_ip      (app_tx_dest_ip),
    .app_tx_dest_port    (app_tx_dest_port),
    .data_pop            (data_pop),
    .ctrl_pop            (ctrl_pop),
    .app_tx_afull        (app_tx_afull),
    .app_tx_overflow     (app_tx_overflow),
    .data_word           (data_word),
    .ctrl_ip             (ctrl_ip),
    .ctrl_port           (ctrl_port),
    .ctrl_words          (ctrl_words),
    .ctrl_empty          (ctrl_empty)
  );

  udp_tx_header_calc i_header_calc (
    .mac_clk       (mac_clk),
    .app_rst       (app_rst),
    .local_ip      (local_ip),
    .local_gateway (local_gateway),
    .arp_wr_en     (arp_wr_en),
    .arp_wr_index  (arp_wr_index),
    .arp_wr_mac    (arp_wr_mac),
    .ctrl_ip       (ctrl_ip),
    .ctrl_words    (ctrl_words),
    .ctrl_empty    (ctrl_empty),
    .ctrl_pop      (ctrl_pop),
    .dest_mac      (dest_mac),
    .ip_length     (ip_length),
    .udp_length    (udp_length),
    .ip_checksum   (ip_checksum),
    .hdr_ready     (hdr_ready)
  );

  udp_tx_framer i_framer (
    .mac_clk           (mac_clk),
    .app_rst           (app_rst),
    .local_enable      (local_enable),
    .local_mac         (local_mac),
    .local_ip          (local_ip),
    .local_port        (local_port),
    .app_tx_overflow   (app_tx_overflow),
    .ctrl_ip           (ctrl_ip),
    .ctrl_port         (ctrl_port),
    .ctrl_words        (ctrl_words),
    .ctrl_empty        (ctrl_empty),
    .dest_mac          (dest_mac),
    .ip_length         (ip_length),
    .udp_length        (udp_length),
    .ip_checksum       (ip_checksum),
    .hdr_ready         (hdr_ready),
    .data_word         (data_word),
    .mac_tx_ack        (mac_tx_ack),
    .data_pop          (data_pop),
    .ctrl_pop          (ctrl_pop),
    .mac_tx_data       (mac_tx_data),
    .mac_tx_data_valid (mac_tx_data_valid),
    .mac_tx_start      (mac_tx_start)
  );

endmodule

/* hw/udp_tx_framer.sv */
`timescale 1ns/1ps

module udp_tx_framer
  import udp_tx_pkg::*;
(
  input  logic        mac_clk,
  input  logic        app_rst,
  input  logic        local_enable,
  input  mac_addr_t   local_mac,
  input  ip_addr_t    local_ip,
  input  udp_port_t   local_port,
  input  logic        app_tx_overflow,
  input  ip_addr_t    ctrl_ip,
  input  udp_port_t   ctrl_port,
  input  word_count_t ctrl_words,
  input  logic        ctrl_empty,
  input  mac_addr_t   dest_mac,
  input  logic [15:0] ip_length,
  input  logic [15:0] udp_length,
  input  logic [15:0] ip_checksum,
  input  logic        hdr_ready,
  input  word_t       data_word,
  input  logic        mac_tx_ack,
  output logic        data_pop,
  output logic        ctrl_pop,
  output word_t       mac_tx_data,
  output byte_en_t    mac_tx_data_valid,
  output logic        mac_tx_start
);

  tx_state_t   state;
  word_count_t remaining;
  logic [15:0] leftover;
  word_t       wire_word;
  logic        go;

  // Wire order (first byte in bits 63:56) to MAC lane order
  function automatic word_t to_lanes(word_t w);
    word_t r;
    for (int i = 0; i < 8; i++) begin
      r[8*i +: 8] = w[8*(7-i) +: 8];
    end
    return r;
  endfunction

  assign go           = hdr_ready && !ctrl_empty && local_enable && !app_tx_overflow;
  assign mac_tx_start = (state == tx_idle) && go;
  assign data_pop     = (state == tx_hdr_6) || (state == tx_data);
  assign ctrl_pop     = state == tx_last;

  // Last two bytes of each word spill into the next beat
  always_ff @(posedge mac_clk) begin
    leftover <= data_word[15:0];
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      state             <= tx_idle;
      remaining         <= '0;
      mac_tx_data_valid <= '0;
    end else begin
      case (state)
        tx_idle: begin
          if (go) begin
            mac_tx_data_valid <= byte_en_all;
            remaining         <= ctrl_words - 16'd1;
            state             <= tx_hdr_1;
          end
        end
        tx_hdr_1: begin
          if (mac_tx_ack) begin
            state <= tx_hdr_2;
          end
        end
        tx_hdr_2: state <= tx_hdr_3;
        tx_hdr_3: state <= tx_hdr_4;
        tx_hdr_4: state <= tx_hdr_5;
        tx_hdr_5: state <= tx_hdr_6;
        tx_hdr_6, tx_data: begin
          remaining <= remaining - 16'd1;
          if (remaining == '0) begin
            mac_tx_data_valid <= byte_en_last;
            state             <= tx_last;
          end else begin
            state <= tx_data;
          end
        end
        tx_last: begin
          mac_tx_data_valid <= '0;
          state             <= tx_idle;
        end
        default: state <= tx_idle;
      endcase
    end
  end

  always_comb begin
    case (state)
      tx_hdr_1: wire_word = {dest_mac, local_mac[47:32]};
      tx_hdr_2: wire_word = {local_mac[31:0], ethertype_ipv4, ip_ver_ihl, 8'h00};
      tx_hdr_3: wire_word = {ip_length, 16'h0000, ip_flags, 8'h00, ip_ttl, ip_proto_udp};
      tx_hdr_4: wire_word = {ip_checksum, local_ip, ctrl_ip[31:16]};
      tx_hdr_5: wire_word = {ctrl_ip[15:0], local_port, ctrl_port, udp_length};
      // UDP checksum left at zero
      tx_hdr_6: wire_word = {16'h0000, data_word[63:16]};
      tx_data:  wire_word = {leftover, data_word[63:16]};
      tx_last:  wire_word = {leftover, 48'h0};
      default:  wire_word = '0;
    endcase
  end

  assign mac_tx_data = to_lanes(wire_word);

  // Start only on a quiet bus, first header beat follows at once
  a_start_idle: assert property (@(posedge mac_clk) disable iff (app_rst)
    mac_tx_start |-> (mac_tx_data_valid == '0) ##1 (mac_tx_data_valid == byte_en_all));

  a_pop_nonempty: assert property (@(posedge mac_clk) disable iff (app_rst)
    data_pop |-> !ctrl_empty);

endmodule

/* hw/udp_tx_header_calc.sv */
`timescale 1ns/1ps

module udp_tx_header_calc
  import udp_tx_pkg::*;
(
  input  logic        mac_clk,
  input  logic        app_rst,
  input  ip_addr_t    local_ip,
  input  arp_index_t  local_gateway,
  input  logic        arp_wr_en,
  input  arp_index_t  arp_wr_index,
  input  mac_addr_t   arp_wr_mac,
  input  ip_addr_t    ctrl_ip,
  input  word_count_t ctrl_words,
  input  logic        ctrl_empty,
  input  logic        ctrl_pop,
  output mac_addr_t   dest_mac,
  output logic [15:0] ip_length,
  output logic [15:0] udp_length,
  output logic [15:0] ip_checksum,
  output logic        hdr_ready
);

  mac_addr_t   arp_table [256];
  arp_index_t  arp_index;
  logic [15:0] ip_len_next;
  logic [18:0] sum_0;
  logic [16:0] sum_1;
  logic [1:0]  settle_cnt;

  // Off-subnet destinations go through the gateway entry
  assign arp_index = (ctrl_ip[31:8] != local_ip[31:8]) ? local_gateway : ctrl_ip[7:0];

  always_ff @(posedge mac_clk) begin
    if (arp_wr_en) begin
      arp_table[arp_wr_index] <= arp_wr_mac;
    end
    dest_mac <= arp_table[arp_index];
  end

  assign ip_len_next = (ctrl_words << 3) + ip_hdr_extra;

  // Stage 1 lengths and raw sum, stage 2 first fold, stage 3 final fold and invert
  always_ff @(posedge mac_clk) begin
    ip_length  <= ip_len_next;
    udp_length <= (ctrl_words << 3) + udp_hdr_extra;
    sum_0 <= {3'b000, ip_fixed_sum}
           + {3'b000, ip_len_next}
           + {3'b000, local_ip[31:16]}
           + {3'b000, local_ip[15:0]}
           + {3'b000, ctrl_ip[31:16]}
           + {3'b000, ctrl_ip[15:0]};
    sum_1       <= {1'b0, sum_0[15:0]} + {14'b0, sum_0[18:16]};
    ip_checksum <= ~(sum_1[15:0] + {15'b0, sum_1[16]});
  end

  // Count pipeline fill after a new control head shows up
  always_ff @(posedge mac_clk) begin
    if (app_rst || ctrl_pop || ctrl_empty) begin
      settle_cnt <= '0;
    end else if (!hdr_ready) begin
      settle_cnt <= settle_cnt + 2'd1;
    end
  end

  assign hdr_ready = settle_cnt == 2'(hdr_calc_latency);

endmodule

/* hw/udp_tx_frame_buffer.sv */
`timescale 1ns/1ps

module udp_tx_frame_buffer
  import udp_tx_pkg::*;
(
  input  logic        mac_clk,
  input  logic        app_rst,
  input  logic        app_tx_valid,
  input  logic        app_tx_end_of_frame,
  input  word_t       app_tx_data,
  input  ip_addr_t    app_tx_dest_ip,
  input  udp_port_t   app_tx_dest_port,
  input  logic        data_pop,
  input  logic        ctrl_pop,
  output logic        app_tx_afull,
  output logic        app_tx_overflow,
  output word_t       data_word,
  output ip_addr_t    ctrl_ip,
  output udp_port_t   ctrl_port,
  output word_count_t ctrl_words,
  output logic        ctrl_empty
);

  logic        valid_r;
  logic        ctrl_wr;
  word_t       data_r;
  ip_addr_t    ip_r;
  udp_port_t   port_r;
  word_count_t word_cnt;
  ctrl_entry_t ctrl_wr_entry;
  ctrl_entry_t ctrl_rd_entry;
  logic        data_afull;
  logic        ctrl_afull;
  logic        data_ovf;
  logic        ctrl_ovf;

  always_ff @(posedge mac_clk) begin
    data_r <= app_tx_data;
    ip_r   <= app_tx_dest_ip;
    port_r <= app_tx_dest_port;
    if (app_rst) begin
      valid_r <= 1'b0;
      ctrl_wr <= 1'b0;
    end else begin
      valid_r <= app_tx_valid;
      ctrl_wr <= app_tx_valid && app_tx_end_of_frame;
    end
  end

  // Starts at one so the end-of-frame word is already counted
  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      word_cnt <= 16'd1;
    end else if (ctrl_wr) begin
      word_cnt <= 16'd1;
    end else if (valid_r) begin
      word_cnt <= word_cnt + 16'd1;
    end
  end

  assign ctrl_wr_entry = {word_cnt, port_r, ip_r};

  udp_tx_sync_fifo #(
    .width ($bits(word_t)),
    .depth (data_fifo_depth)
  ) i_data_fifo (
    .mac_clk  (mac_clk),
    .app_rst  (app_rst),
    .wr_en    (valid_r),
    .wr_data  (data_r),
    .rd_en    (data_pop),
    .rd_data  (data_word),
    .empty    (),
    .afull    (data_afull),
    .overflow (data_ovf)
  );

  udp_tx_sync_fifo #(
    .width ($bits(ctrl_entry_t)),
    .depth (ctrl_fifo_depth)
  ) i_ctrl_fifo (
    .mac_clk  (mac_clk),
    .app_rst  (app_rst),
    .wr_en    (ctrl_wr),
    .wr_data  (ctrl_wr_entry),
    .rd_en    (ctrl_pop),
    .rd_data  (ctrl_rd_entry),
    .empty    (ctrl_empty),
    .afull    (ctrl_afull),
    .overflow (ctrl_ovf)
  );

  assign ctrl_words = ctrl_rd_entry[63:48];
  assign ctrl_port  = ctrl_rd_entry[47:32];
  assign ctrl_ip    = ctrl_rd_entry[31:0];

  assign app_tx_afull = data_afull || ctrl_afull;

  // Sticky until reset, holds off any further frames
  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      app_tx_overflow <= 1'b0;
    end else if (data_ovf || ctrl_ovf) begin
      app_tx_overflow <= 1'b1;
    end
  end

endmodule

/* hw/udp_tx_sync_fifo.sv */
`timescale 1ns/1ps

module udp_tx_sync_fifo
  import udp_tx_pkg::*;
#(
  parameter int width = 64,
  parameter int depth = 512
) (
  input  logic             mac_clk,
  input  logic             app_rst,
  input  logic             wr_en,
  input  logic [width-1:0] wr_data,
  input  logic             rd_en,
  output logic [width-1:0] rd_data,
  output logic             empty,
  output logic             afull,
  output logic             overflow
);

  logic [width-1:0]         mem [depth];
  logic [$clog2(depth)-1:0] wr_ptr;
  logic [$clog2(depth)-1:0] rd_ptr;
  logic [$clog2(depth):0]   count;
  logic                     full;
  logic                     do_wr;
  logic                     do_rd;

  assign full  = count == ($clog2(depth) + 1)'(depth);
  assign empty = count == '0;
  // Fewer than the margin left free
  assign afull = count > (depth - fifo_afull_margin);

  // Writes into a full FIFO are lost
  assign do_wr    = wr_en && !full;
  assign do_rd    = rd_en && !empty;
  assign overflow = wr_en && full;

  // Head word is visible without a read strobe
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_read_empty: assert property (@(posedge mac_clk) disable iff (app_rst)
    rd_en |-> !empty);

endmodule

/* hw/udp_tx_pkg.sv */
package udp_tx_pkg;

  // Widths with a meaning of their own
  typedef logic [63:0] word_t;
  typedef logic [7:0]  byte_en_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] word_count_t;
  typedef logic [7:0]  arp_index_t;

  // Control FIFO entry: {word count, dest port, dest ip}
  typedef logic [63:0] ctrl_entry_t;

  typedef enum logic [3:0] {
    tx_idle,
    tx_hdr_1,
    tx_hdr_2,
    tx_hdr_3,
    tx_hdr_4,
    tx_hdr_5,
    tx_hdr_6,
    tx_data,
    tx_last
  } tx_state_t;

  localparam int data_fifo_depth   = 512;
  localparam int ctrl_fifo_depth   = 16;
  localparam int fifo_afull_margin = 8;

  // Folded sum of version/IHL, flags, TTL and protocol
  localparam logic [15:0] ip_fixed_sum = 16'h8412;

  localparam logic [15:0] ethertype_ipv4 = 16'h0800;
  localparam logic [7:0]  ip_ver_ihl     = 8'h45;
  localparam logic [7:0]  ip_flags       = 8'h40;
  localparam logic [7:0]  ip_ttl         = 8'hff;
  localparam logic [7:0]  ip_proto_udp   = 8'h11;

  // Header bytes added to the payload for the IP and UDP lengths
  localparam logic [15:0] ip_hdr_extra  = 16'd28;
  localparam logic [15:0] udp_hdr_extra = 16'd8;

  localparam byte_en_t byte_en_all  = 8'hff;
  localparam byte_en_t byte_en_last = 8'b0000_0011;

  localparam int hdr_calc_latency = 3;

endpackage
